// ==== nvic_main.f ====
design/nvic_pkg.sv
design/nvic_pend_tree.sv
design/nvic_active_decode.sv
design/nvic_pend_select.sv
design/nvic_main.sv
tests/nvic_clk_gen.sv
tests/nvic_checker.sv
tests/tb_nvic_main.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the NVIC testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal \
   -f nvic_main.f \
   --top-module tb_nvic_main \
   -o sim_nvic > build.log 2>&1
if [ $? -ne 0 ]; then
   echo "compile failed, see build.log"
   exit 1
fi

./obj_dir/sim_nvic > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
   echo "simulation exited with status $run_status"
   exit 1
fi

if grep -q "TEST PASSED" sim.log; then
   exit 0
else
   exit 1
fi

// ==== tests/tb_nvic_main.sv ====
// NVIC prioritisation testbench

`timescale 1ns/1ps

module tb_nvic_main;

   typedef struct packed {
      nvic_pkg::pend_req_t  pend;
      logic [31:0]          en;
      nvic_pkg::prio_cfg_t  prio;
      nvic_pkg::core_stat_t core;
      logic                 dbg;
      logic                 e_pend;
      nvic_pkg::vec_t       e_num;
      logic                 e_wfi;
      logic                 e_esc;
      nvic_pkg::actv_bits_t e_actv;
   } row_t;

   logic                 sclk;
   logic                 hreset_n;
   nvic_pkg::pend_req_t  pend;
   logic [31:0]          en;
   nvic_pkg::prio_cfg_t  prio;
   nvic_pkg::core_stat_t core;
   logic                 dbg;
   nvic_pkg::actv_bits_t actv_bit;
   logic                 svc_esc;
   logic                 int_pend;
   nvic_pkg::vec_t       int_num;
   logic                 wfi_adv;
   logic                 chk_en;
   row_t                 cur;
   row_t                 rows[$];
   int                   err_cnt;
   int                   chk_cnt;

   nvic_clk_gen u_clk (.sclk_o(sclk), .hreset_n_o(hreset_n));

   nvic_main DUT
      (.sclk(sclk), .hreset_n(hreset_n), .pend_i(pend), .irq_en_i(en), .prio_i(prio),
       .core_i(core), .dbg_maskints_i(dbg), .actv_bit_o(actv_bit),
       .svc_escalate_o(svc_esc), .int_pend_o(int_pend), .int_pend_num_o(int_num),
       .wfi_advance_o(wfi_adv));

   nvic_checker u_chk
      (.sclk(sclk), .hreset_n(hreset_n), .chk_en_i(chk_en),
       .exp_pend_i(cur.e_pend), .exp_num_i(cur.e_num), .exp_wfi_i(cur.e_wfi),
       .exp_esc_i(cur.e_esc), .exp_actv_i(cur.e_actv),
       .int_pend_i(int_pend), .int_pend_num_i(int_num), .wfi_advance_i(wfi_adv),
       .svc_escalate_i(svc_esc), .actv_bit_i(actv_bit),
       .err_cnt_o(err_cnt), .chk_cnt_o(chk_cnt));

   // -------------------------------------------------------------------
   // row helpers
   // -------------------------------------------------------------------

   // svc 1, pendsv 2, systick 3, every IRQ 2
   function automatic nvic_pkg::prio_cfg_t base_prio();
      nvic_pkg::prio_cfg_t p;
      p.svc_lvl = 2'd1;
      p.psv_lvl = 2'd2;
      p.tck_lvl = 2'd3;
      p.irq_lvl = {32{2'd2}};
      return p;
   endfunction

   function automatic nvic_pkg::core_stat_t core_of(nvic_pkg::vec_t ipsr, logic prim,
                                                    logic nmi, logic hdf);
      nvic_pkg::core_stat_t c;
      c.ipsr       = ipsr;
      c.primask_ex = prim;
      c.nmi_active = nmi;
      c.hdf_active = hdf;
      return c;
   endfunction

   // single active bit or an empty list for a negative index
   function automatic nvic_pkg::actv_bits_t actv_of(int idx);
      logic [36:0] v;
      v = '0;
      if (idx >= 0)
         v[idx] = 1'b1;
      return nvic_pkg::actv_bits_t'(v);
   endfunction

   // reference IRQ pick returning {found, vector}, lowest level then lowest number
   function automatic logic [6:0] irq_winner(logic [31:0] req, nvic_pkg::prio_cfg_t p);
      logic   found;
      logic [1:0] best;
      logic [5:0] vec;
      found = 1'b0;
      best  = 2'd3;
      vec   = 6'd0;
      for (int n = 0; n < 32; n++)
      begin
         if (req[n] && (!found || p.irq_lvl[n] < best))
         begin
            found = 1'b1;
            best  = p.irq_lvl[n];
            vec   = 6'(16 + n);
         end
      end
      return {found, vec};
   endfunction

   task automatic add_row(nvic_pkg::pend_req_t pd, logic [31:0] e, nvic_pkg::prio_cfg_t p,
                          nvic_pkg::core_stat_t c, logic d, logic xp, nvic_pkg::vec_t xn,
                          logic xw, logic xe, nvic_pkg::actv_bits_t xa);
      row_t r;
      r = {pd, e, p, c, d, xp, xn, xw, xe, xa};
      rows.push_back(r);
   endtask

   // -------------------------------------------------------------------
   // table
   // -------------------------------------------------------------------

   task automatic build_table();
      nvic_pkg::pend_req_t pz;
      nvic_pkg::pend_req_t pd;
      nvic_pkg::prio_cfg_t p;
      nvic_pkg::prio_cfg_t pb;
      logic [31:0]         e;
      logic [6:0]          w;
      pz = '0;
      pb = base_prio();
      // active decode, nothing pending
      add_row(pz, '0, pb, core_of(6'd0, 0, 0, 0), 0, 0, 6'd0, 0, 0, actv_of(-1));
      add_row(pz, '0, pb, core_of(6'd2, 0, 1, 0), 0, 0, 6'd0, 0, 0, actv_of(0));
      add_row(pz, '0, pb, core_of(6'd3, 0, 0, 1), 0, 0, 6'd0, 0, 0, actv_of(1));
      add_row(pz, '0, pb, core_of(6'd11, 0, 0, 0), 0, 0, 6'd0, 0, 1, actv_of(2));
      add_row(pz, '0, pb, core_of(6'd14, 0, 0, 0), 0, 0, 6'd0, 0, 0, actv_of(3));
      add_row(pz, '0, pb, core_of(6'd15, 0, 0, 0), 0, 0, 6'd0, 0, 0, actv_of(4));
      add_row(pz, '0, pb, core_of(6'd16, 0, 0, 0), 0, 0, 6'd0, 0, 0, actv_of(5));
      add_row(pz, '0, pb, core_of(6'd31, 0, 0, 0), 0, 0, 6'd0, 0, 0, actv_of(20));
      add_row(pz, '0, pb, core_of(6'd47, 0, 0, 0), 0, 0, 6'd0, 0, 0, actv_of(36));
      // svc escalation against a level 0 IRQ
      p = pb;
      p.irq_lvl[3] = 2'd0;
      add_row(pz, '0, p, core_of(6'd19, 0, 0, 0), 0, 0, 6'd0, 0, 1, actv_of(8));

      // IRQ tie goes to 3 and disabled 7 is ignored
      p = pb;
      p.irq_lvl[3] = 2'd1;
      p.irq_lvl[5] = 2'd1;
      p.irq_lvl[7] = 2'd0;
      pd = pz;
      pd.irq = 32'h0000_00a8;
      add_row(pd, 32'h0000_0028, p, core_of(6'd0, 0, 0, 0), 0, 1, 6'd19, 1, 0, actv_of(-1));
      add_row(pz, 32'hffff_ffff, p, core_of(6'd0, 0, 0, 0), 0, 0, 6'd0, 0, 0, actv_of(-1));

      // random IRQ mixes with thread mode
      for (int i = 0; i < 8; i++)
      begin
         p = pb;
         for (int n = 0; n < 32; n++)
            p.irq_lvl[n] = 2'($urandom);
         pd = pz;
         pd.irq = $urandom;
         e = $urandom;
         w = irq_winner(pd.irq & e, p);
         add_row(pd, e, p, core_of(6'd0, 0, 0, 0), 0, w[6], w[5:0], w[6], 0, actv_of(-1));
      end

      // threshold against IRQ0 at level 2
      p = pb;
      pd = pz;
      pd.irq[5] = 1'b1;
      add_row(pd, 32'h20, p, core_of(6'd16, 0, 0, 0), 0, 0, 6'd21, 0, 0, actv_of(5));
      p.irq_lvl[5] = 2'd1;
      add_row(pd, 32'h20, p, core_of(6'd16, 0, 0, 0), 0, 1, 6'd21, 1, 0, actv_of(5));
      // NMI over everything, then blocked by itself
      pd.nmi = 1'b1;
      add_row(pd, 32'h20, p, core_of(6'd16, 0, 0, 0), 0, 1, 6'd2, 1, 0, actv_of(5));
      add_row(pd, 32'h20, p, core_of(6'd2, 0, 1, 0), 0, 0, 6'd2, 0, 0, actv_of(0));
      // HardFault taken, then blocked while running
      pd = pz;
      pd.hdf = 1'b1;
      add_row(pd, '0, p, core_of(6'd0, 0, 0, 0), 0, 1, 6'd3, 1, 0, actv_of(-1));
      add_row(pd, '0, p, core_of(6'd3, 0, 0, 1), 0, 0, 6'd3, 0, 0, actv_of(1));
      // a running NMI also holds off HardFault
      add_row(pd, '0, p, core_of(6'd2, 0, 1, 0), 0, 0, 6'd3, 0, 0, actv_of(0));

      // primask holds the request but wfi still wakes
      pd = pz;
      pd.irq[5] = 1'b1;
      add_row(pd, 32'h20, p, core_of(6'd0, 1, 0, 0), 0, 0, 6'd21, 1, 0, actv_of(-1));
      // debug mask hides the IRQ
      add_row(pd, 32'h20, p, core_of(6'd0, 0, 0, 0), 1, 0, 6'd0, 0, 0, actv_of(-1));
      // PendSV and SysTick outrank SVCall until the debug mask hides them
      p.psv_lvl = 2'd0;
      p.tck_lvl = 2'd0;
      pd.psv = 1'b1;
      pd.tck = 1'b1;
      pd.svc = 1'b1;
      add_row(pd, 32'h20, p, core_of(6'd0, 0, 0, 0), 0, 1, 6'd14, 1, 0, actv_of(-1));
      add_row(pd, 32'h20, p, core_of(6'd0, 0, 0, 0), 1, 1, 6'd11, 1, 0, actv_of(-1));
   endtask

   // -------------------------------------------------------------------
   // run
   // -------------------------------------------------------------------

   initial
   begin
      int wait_cnt;
      pend   = '0;
      en     = '0;
      prio   = '0;
      core   = '0;
      dbg    = 1'b0;
      chk_en = 1'b0;
      cur    = '0;
      void'($urandom(32'hb07a));
      build_table();

      wait_cnt = 0;
      while (!hreset_n && wait_cnt < 50)
      begin
         @(posedge sclk);
         wait_cnt++;
      end
      if (!hreset_n)
      begin
         $display("timeout: reset was never released");
         $display("TEST FAILED");
         $finish;
      end
      else
      begin
         foreach (rows[i])
         begin
            @(posedge sclk);
            #2;
            pend   = rows[i].pend;
            en     = rows[i].en;
            prio   = rows[i].prio;
            core   = rows[i].core;
            dbg    = rows[i].dbg;
            cur    = rows[i];
            chk_en = 1'b1;
         end
         // last row is compared here
         @(posedge sclk);
         #1;
         chk_en = 1'b0;
         $display("checks %0d rows %0d errors %0d", chk_cnt, rows.size(), err_cnt);
         if (err_cnt == 0 && chk_cnt == rows.size())
            $display("TEST PASSED");
         else
            $display("TEST FAILED");
         $finish;
      end
   end

endmodule

// ==== tests/nvic_checker.sv ====
// NVIC output checker

`timescale 1ns/1ps

module nvic_checker
   (input  logic                 sclk,
    input  logic                 hreset_n,
    input  logic                 chk_en_i,
    // expected row
    input  logic                 exp_pend_i,
    input  nvic_pkg::vec_t       exp_num_i,
    input  logic                 exp_wfi_i,
    input  logic                 exp_esc_i,
    input  nvic_pkg::actv_bits_t exp_actv_i,
    // DUT outputs
    input  logic                 int_pend_i,
    input  nvic_pkg::vec_t       int_pend_num_i,
    input  logic                 wfi_advance_i,
    input  logic                 svc_escalate_i,
    input  nvic_pkg::actv_bits_t actv_bit_i,
    output int                   err_cnt_o,
    output int                   chk_cnt_o);

   initial
   begin
      err_cnt_o = 0;
      chk_cnt_o = 0;
   end

   // -------------------------------------------------------------------
   // compare on the edge after the row was driven
   // -------------------------------------------------------------------

   always @(posedge sclk)
   begin
      if (hreset_n && chk_en_i)
      begin
         chk_cnt_o = chk_cnt_o + 1;
         if (int_pend_i !== exp_pend_i)
         begin
            $display("error at %0t: int_pend got %b exp %b", $time, int_pend_i, exp_pend_i);
            err_cnt_o = err_cnt_o + 1;
         end
         if (int_pend_num_i !== exp_num_i)
         begin
            $display("error at %0t: vector got %0d exp %0d", $time, int_pend_num_i, exp_num_i);
            err_cnt_o = err_cnt_o + 1;
         end
         if (wfi_advance_i !== exp_wfi_i)
         begin
            $display("error at %0t: wfi_advance got %b exp %b", $time, wfi_advance_i,
                     exp_wfi_i);
            err_cnt_o = err_cnt_o + 1;
         end
         if (svc_escalate_i !== exp_esc_i)
         begin
            $display("error at %0t: svc_escalate got %b exp %b", $time, svc_escalate_i,
                     exp_esc_i);
            err_cnt_o = err_cnt_o + 1;
         end
         // whole active list in one go
         if (actv_bit_i !== exp_actv_i)
         begin
            $display("error at %0t: actv_bit got %h exp %h", $time, actv_bit_i, exp_actv_i);
            err_cnt_o = err_cnt_o + 1;
         end
      end
   end

endmodule

// ==== tests/nvic_clk_gen.sv ====
// NVIC testbench clock and reset

`timescale 1ns/1ps

module nvic_clk_gen
   (output logic sclk_o,
    output logic hreset_n_o);

   // 20 ns period
   initial
   begin
      sclk_o = 1'b0;
      forever #10 sclk_o = ~sclk_o;
   end

   // reset held for 10 rising edges
   initial
   begin
      hreset_n_o = 1'b0;
      repeat (10) @(posedge sclk_o);
      #2 hreset_n_o = 1'b1;
   end

endmodule

// ==== design/nvic_main.sv ====
// NVIC prioritisation top level

`timescale 1ns/1ps

module nvic_main
   (input  logic                          sclk,
    input  logic                          hreset_n,
    // pend, enable and priority state from the register block
    input  nvic_pkg::pend_req_t           pend_i,
    input  logic [nvic_pkg::NUM_IRQ-1:0]  irq_en_i,
    input  nvic_pkg::prio_cfg_t           prio_i,
    // core state and debug masking
    input  nvic_pkg::core_stat_t          core_i,
    input  logic                          dbg_maskints_i,
    // results to the core
    output nvic_pkg::actv_bits_t          actv_bit_o,
    output logic                          svc_escalate_o,
    output logic                          int_pend_o,
    output nvic_pkg::vec_t                int_pend_num_o,
    output logic                          wfi_advance_o);

   // -------------------------------------------------------------------
   // active handler info into the selector
   // -------------------------------------------------------------------

   logic           int_actv;
   nvic_pkg::lvl_t int_actv_lvl;

   nvic_active_decode u_active
      (.sclk           (sclk),
       .hreset_n       (hreset_n),
       .core_i         (core_i),
       .prio_i         (prio_i),
       .actv_bit_o     (actv_bit_o),
       .int_actv_o     (int_actv),
       .int_actv_lvl_o (int_actv_lvl),
       .svc_escalate_o (svc_escalate_o));

   // tournament and final preempt decision
   nvic_pend_select u_select
      (.sclk           (sclk),
       .hreset_n       (hreset_n),
       .pend_i         (pend_i),
       .irq_en_i       (irq_en_i),
       .prio_i         (prio_i),
       .core_i         (core_i),
       .dbg_maskints_i (dbg_maskints_i),
       .int_actv_i     (int_actv),
       .int_actv_lvl_i (int_actv_lvl),
       .int_pend_o     (int_pend_o),
       .int_pend_num_o (int_pend_num_o),
       .wfi_advance_o  (wfi_advance_o));

endmodule

// ==== design/nvic_pend_select.sv ====
// NVIC pending selection and preemption

`timescale 1ns/1ps

module nvic_pend_select
   (input  logic                          sclk,
    input  logic                          hreset_n,
    input  nvic_pkg::pend_req_t           pend_i,
    input  logic [nvic_pkg::NUM_IRQ-1:0]  irq_en_i,
    input  nvic_pkg::prio_cfg_t           prio_i,
    input  nvic_pkg::core_stat_t          core_i,
    input  logic                          dbg_maskints_i,
    input  logic                          int_actv_i,
    input  nvic_pkg::lvl_t                int_actv_lvl_i,
    output logic                          int_pend_o,
    output nvic_pkg::vec_t                int_pend_num_o,
    output logic                          wfi_advance_o);

   nvic_pkg::cand_t [nvic_pkg::NUM_IRQ-1:0] irq_leaf;
   nvic_pkg::cand_t                         irq_win;
   nvic_pkg::cand_t [3:0]                   sys_leaf;
   nvic_pkg::cand_t                         tree_win;
   nvic_pkg::vec_t                          tree_num;
   logic                                    n_or_h;
   logic                                    nmi_preempt;
   logic                                    hdf_preempt;
   logic                                    lvl_ok;
   logic                                    tree_req;

   // -------------------------------------------------------------------
   // IRQ tournament
   // -------------------------------------------------------------------

   genvar n;
   generate
      for (n = 0; n < nvic_pkg::NUM_IRQ; n++)
      begin : g_leaf
         assign irq_leaf[n].en_pend = pend_i.irq[n] & irq_en_i[n];
         assign irq_leaf[n].lvl     = prio_i.irq_lvl[n];
         assign irq_leaf[n].vec     = nvic_pkg::vec_t'(nvic_pkg::IRQ0_VEC + n);
      end
   endgenerate

   nvic_pend_tree #(.NUM_LEAF(nvic_pkg::NUM_IRQ)) u_irq_tree
      (.sclk     (sclk),
       .hreset_n (hreset_n),
       .leaf_i   (irq_leaf),
       .win_o    (irq_win));

   // -------------------------------------------------------------------
   // system handlers plus IRQ winner
   // -------------------------------------------------------------------

   // debug masking hides everything but SVCall, an SVC must still be taken
   assign sys_leaf[0] = '{en_pend: pend_i.svc, lvl: prio_i.svc_lvl, vec: nvic_pkg::SVC_VEC};
   assign sys_leaf[1] = '{en_pend: pend_i.psv & ~dbg_maskints_i,
                          lvl:     prio_i.psv_lvl,
                          vec:     nvic_pkg::PSV_VEC};
   assign sys_leaf[2] = '{en_pend: pend_i.tck & ~dbg_maskints_i,
                          lvl:     prio_i.tck_lvl,
                          vec:     nvic_pkg::TCK_VEC};
   // IRQ winner goes last, it carries the highest vector numbers
   assign sys_leaf[3] = '{en_pend: irq_win.en_pend & ~dbg_maskints_i,
                          lvl:     irq_win.lvl,
                          vec:     irq_win.vec};

   nvic_pend_tree #(.NUM_LEAF(4)) u_sys_tree
      (.sclk     (sclk),
       .hreset_n (hreset_n),
       .leaf_i   (sys_leaf),
       .win_o    (tree_win));

   // vector reads as zero when the tree is empty
   assign tree_num = tree_win.vec & {6{tree_win.en_pend}};

   // -------------------------------------------------------------------
   // preemption
   // -------------------------------------------------------------------

   assign n_or_h = core_i.nmi_active | core_i.hdf_active;

   // NMI only blocks itself, HardFault is blocked by either
   assign nmi_preempt = pend_i.nmi & ~core_i.nmi_active;
   assign hdf_preempt = pend_i.hdf & ~n_or_h;

   // strictly higher priority needed, thread mode accepts anything
   assign lvl_ok   = (tree_win.lvl < int_actv_lvl_i) | ~int_actv_i;
   assign tree_req = tree_win.en_pend & lvl_ok & ~n_or_h;

   // PRIMASK holds off the exception but a sleeping WFI still wakes
   assign wfi_advance_o = tree_req | nmi_preempt | hdf_preempt;
   assign int_pend_o    = (tree_req & ~core_i.primask_ex) | nmi_preempt | hdf_preempt;

   assign int_pend_num_o = pend_i.nmi ? nvic_pkg::NMI_VEC :
                           pend_i.hdf ? nvic_pkg::HDF_VEC :
                                        tree_num;

   // request must always point at an implemented exception
   a_pend_vec_valid: assert property (@(posedge sclk) disable iff (!hreset_n)
      int_pend_o |-> ((int_pend_num_o == nvic_pkg::NMI_VEC) ||
                      (int_pend_num_o == nvic_pkg::HDF_VEC) ||
                      (int_pend_num_o == nvic_pkg::SVC_VEC) ||
                      (int_pend_num_o == nvic_pkg::PSV_VEC) ||
                      (int_pend_num_o == nvic_pkg::TCK_VEC) ||
                      ((int_pend_num_o >= nvic_pkg::IRQ0_VEC) &&
                       (int_pend_num_o < nvic_pkg::IRQ0_VEC + nvic_pkg::NUM_IRQ))));

endmodule

// ==== design/nvic_active_decode.sv ====
// NVIC active exception decode

`timescale 1ns/1ps

module nvic_active_decode
   (input  logic                   sclk,
    input  logic                   hreset_n,
    input  nvic_pkg::core_stat_t   core_i,
    input  nvic_pkg::prio_cfg_t    prio_i,
    output nvic_pkg::actv_bits_t   actv_bit_o,
    output logic                   int_actv_o,
    output nvic_pkg::lvl_t         int_actv_lvl_o,
    output logic                   svc_escalate_o);

   // -------------------------------------------------------------------
   // which handler is running
   // -------------------------------------------------------------------

   logic                          svc_actv;
   logic                          psv_actv;
   logic                          tck_actv;
   logic [nvic_pkg::NUM_IRQ-1:0]  irq_actv;
   // per-IRQ level bits gated by the active flag
   logic [nvic_pkg::NUM_IRQ-1:0]  irq_lvl_hi;
   logic [nvic_pkg::NUM_IRQ-1:0]  irq_lvl_lo;
   nvic_pkg::lvl_t                irq_actv_lvl;
   logic [nvic_pkg::NUM_ACTV-1:0] actv_flat;

   // system handlers are plain compares against ipsr
   assign svc_actv = (core_i.ipsr == nvic_pkg::SVC_VEC);
   assign psv_actv = (core_i.ipsr == nvic_pkg::PSV_VEC);
   assign tck_actv = (core_i.ipsr == nvic_pkg::TCK_VEC);

   genvar n;
   generate
      for (n = 0; n < nvic_pkg::NUM_IRQ; n++)
      begin : g_irq
         assign irq_actv[n]   = (core_i.ipsr == nvic_pkg::vec_t'(nvic_pkg::IRQ0_VEC + n));
         assign irq_lvl_hi[n] = irq_actv[n] & prio_i.irq_lvl[n][1];
         assign irq_lvl_lo[n] = irq_actv[n] & prio_i.irq_lvl[n][0];
      end
   endgenerate

   // at most one IRQ bit survives, so a plain OR picks its level
   assign irq_actv_lvl = {|irq_lvl_hi, |irq_lvl_lo};

   // -------------------------------------------------------------------
   // active level and list
   // -------------------------------------------------------------------

   // NMI and HardFault are not prioritisable and stay out of int_actv
   assign int_actv_o = (|irq_actv) | tck_actv | psv_actv | svc_actv;

   assign int_actv_lvl_o = irq_actv_lvl                           |
                           ({2{tck_actv}} & prio_i.tck_lvl)       |
                           ({2{psv_actv}} & prio_i.psv_lvl)       |
                           ({2{svc_actv}} & prio_i.svc_lvl);

   // core has already decoded NMI and HardFault for us
   assign actv_bit_o.nmi = core_i.nmi_active;
   assign actv_bit_o.hdf = core_i.hdf_active;
   assign actv_bit_o.svc = svc_actv;
   assign actv_bit_o.psv = psv_actv;
   assign actv_bit_o.tck = tck_actv;
   assign actv_bit_o.irq = irq_actv;

   // an SVC at or below the running priority cannot be taken
   assign svc_escalate_o = int_actv_o & (prio_i.svc_lvl >= int_actv_lvl_o);

   // -------------------------------------------------------------------
   // checks
   // -------------------------------------------------------------------

   assign actv_flat = actv_bit_o;

   // core flags and ipsr decode must never claim two handlers
   a_actv_onehot: assert property (@(posedge sclk) disable iff (!hreset_n)
      $onehot0(actv_flat));

endmodule

// ==== design/nvic_pend_tree.sv ====
// NVIC pending tournament tree

`timescale 1ns/1ps

module nvic_pend_tree
  #(parameter int NUM_LEAF = 32)
   (input  logic                             sclk,
    input  logic                             hreset_n,
    input  nvic_pkg::cand_t [NUM_LEAF-1:0]   leaf_i,
    output nvic_pkg::cand_t                  win_o);

   // number of compare stages
   localparam int LVLS = $clog2(NUM_LEAF);

   logic [NUM_LEAF-1:0] leaf_enp;

   // -------------------------------------------------------------------
   // pairwise node
   // -------------------------------------------------------------------

   // lo holds the lower vector number and wins all ties
   function automatic nvic_pkg::cand_t pick
      (input nvic_pkg::cand_t lo,
       input nvic_pkg::cand_t hi);
      logic sel_hi;
      begin
         // hi wins on a strictly better level, or when lo is idle
         sel_hi = (hi.en_pend & (hi.lvl < lo.lvl)) | ~lo.en_pend;
         pick   = sel_hi ? hi : lo;
      end
   endfunction

   // -------------------------------------------------------------------
   // tree
   // -------------------------------------------------------------------

   genvar l;
   genvar k;
   generate
      for (l = 0; l <= LVLS; l++)
      begin : g_lvl
         // stage l keeps half the survivors of stage l-1
         nvic_pkg::cand_t [(NUM_LEAF>>l)-1:0] cand;

         if (l == 0)
         begin : g_in
            assign cand = leaf_i;
         end
         else
         begin : g_cmp
            for (k = 0; k < (NUM_LEAF>>l); k++)
            begin : g_node
               assign cand[k] = pick(g_lvl[l-1].cand[2*k], g_lvl[l-1].cand[2*k+1]);
            end
         end
      end

      for (k = 0; k < NUM_LEAF; k++)
      begin : g_enp
         assign leaf_enp[k] = leaf_i[k].en_pend;
      end
   endgenerate

   assign win_o = g_lvl[LVLS].cand[0];

   // the tree reports a request exactly when one entered at a leaf
   a_win_has_leaf: assert property (@(posedge sclk) disable iff (!hreset_n)
      win_o.en_pend == (|leaf_enp));

endmodule

// ==== design/nvic_pkg.sv ====
// NVIC shared types and constants

package nvic_pkg;

   // -------------------------------------------------------------------
   // sizes
   // -------------------------------------------------------------------

   // all 32 IRQ lines are always implemented
   localparam int NUM_IRQ  = 32;

   // active list width: IRQs plus SysTick, PendSV, SVCall, HardFault, NMI
   localparam int NUM_ACTV = NUM_IRQ + 5;

   // priority level, lower value is higher priority
   typedef logic [1:0] lvl_t;

   // exception vector number
   typedef logic [5:0] vec_t;

   // -------------------------------------------------------------------
   // vector numbers
   // -------------------------------------------------------------------

   localparam vec_t NMI_VEC  = 6'd2;
   localparam vec_t HDF_VEC  = 6'd3;
   localparam vec_t SVC_VEC  = 6'd11;
   localparam vec_t PSV_VEC  = 6'd14;
   localparam vec_t TCK_VEC  = 6'd15;
   // IRQ n sits at IRQ0_VEC + n
   localparam vec_t IRQ0_VEC = 6'd16;

   // -------------------------------------------------------------------
   // bundles
   // -------------------------------------------------------------------

   // one tournament entry, 9 bits
   typedef struct packed {
      logic en_pend;
      lvl_t lvl;
      vec_t vec;
   } cand_t;

   // raw pend bits from the register block
   typedef struct packed {
      logic               nmi;
      logic               hdf;
      logic               svc;
      logic               psv;
      logic               tck;
      logic [NUM_IRQ-1:0] irq;
   } pend_req_t;

   // programmed priorities, irq_lvl[n] belongs to IRQ n
   typedef struct packed {
      lvl_t               svc_lvl;
      lvl_t               psv_lvl;
      lvl_t               tck_lvl;
      lvl_t [NUM_IRQ-1:0] irq_lvl;
   } prio_cfg_t;

   // state forwarded from the core
   typedef struct packed {
      vec_t ipsr;
      // forwarded PRIMASK, not the registered copy
      logic primask_ex;
      logic nmi_active;
      logic hdf_active;
   } core_stat_t;

   // one-hot active list, nmi lands in bit 0 and IRQ n in bit 5+n
   typedef struct packed {
      logic [NUM_IRQ-1:0] irq;
      logic               tck;
      logic               psv;
      logic               svc;
      logic               hdf;
      logic               nmi;
   } actv_bits_t;

endpackage
